//--- hdl/fetch_pkg.sv
// shared codes and structs of the fetch front end
// a loop-register write can address loops 0 and 1 only
`default_nettype none

package fetch_pkg;

  // ----------------------------------------
  // redirect sources
  // ----------------------------------------
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_EXCEPTION,
    PC_MRET,
    PC_DRET,
    PC_FENCEI
  } pc_sel_e;

  // trap vector source inside PC_EXCEPTION
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION,
    EXC_PC_IRQ,
    EXC_PC_DBD
  } exc_sel_e;

  // ----------------------------------------
  // payloads
  // ----------------------------------------
  // one fetched word with the address it came from
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] rdata;
  } fetch_word_t;

  // IF/ID register contents
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        is_compressed;
    logic        illegal_c;
    logic        is_hwlp;
  } if_id_t;

  // one hardware loop
  typedef struct packed {
    logic [31:0] start;
    logic [31:0] end_addr;
    logic [31:0] count;
  } hwlp_cfg_t;

  // loop-register write; sel picks start, end or count
  typedef struct packed {
    logic        valid;
    logic        idx;
    logic [1:0]  sel;
    logic [31:0] data;
  } hwlp_wr_t;

  localparam logic [1:0] HWLP_SEL_START = 2'd0;
  localparam logic [1:0] HWLP_SEL_END   = 2'd1;
  localparam logic [1:0] HWLP_SEL_COUNT = 2'd2;

  // debug module halt entry
  localparam logic [31:0] DEFAULT_DM_HALT_ADDR = 32'h1A11_0800;

endpackage

`default_nettype wire

//--- hdl/fetch_prefetch_buffer.sv
// word requests only; responses must come back in order and are never stalled
// instr_addr_o may change without a grant only in the cycle of a redirect
`timescale 1ns/10ps
`default_nettype none

module fetch_prefetch_buffer #(
  parameter int DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic                   branch_i,
  input  logic [31:0]            branch_addr_i,
  input  logic                   ready_i,
  output logic                   valid_o,
  output fetch_pkg::fetch_word_t word_o,
  output logic                   instr_req_o,
  output logic [31:0]            instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  logic [31:0]            instr_rdata_i,
  output logic                   busy_o
);
  import fetch_pkg::*;

  localparam int PW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  fetch_word_t   fifo_mem [DEPTH];
  logic [PW-1:0] rd_ptr_q, wr_ptr_q;
  logic [CW-1:0] fifo_cnt_q, out_cnt_q, out_cnt_n, drop_cnt_q;
  logic [CW:0]   in_use;
  logic [31:0]   fetch_addr_q, resp_addr_q;
  logic          armed_q;
  logic          granted, drop, push, pop;

  // queued words plus words on the bus bound the request window
  assign in_use       = {1'b0, fifo_cnt_q} + {1'b0, out_cnt_q};
  assign instr_req_o  = armed_q & req_i & (in_use < DEPTH);
  assign instr_addr_o = fetch_addr_q;
  assign granted      = instr_req_o & instr_gnt_i;
  assign out_cnt_n    = out_cnt_q + CW'(granted) - CW'(instr_rvalid_i);

  // responses granted before a redirect are stale
  assign drop = instr_rvalid_i & ((drop_cnt_q != '0) | branch_i);
  assign push = instr_rvalid_i & ~drop;
  assign pop  = valid_o & ready_i & ~branch_i;

  assign valid_o = (fifo_cnt_q != '0);
  assign word_o  = fifo_mem[rd_ptr_q];
  assign busy_o  = instr_req_o | (out_cnt_q != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      armed_q      <= 1'b0;
      fetch_addr_q <= '0;
      resp_addr_q  <= '0;
      out_cnt_q    <= '0;
      drop_cnt_q   <= '0;
      fifo_cnt_q   <= '0;
      rd_ptr_q     <= '0;
      wr_ptr_q     <= '0;
    end else begin
      out_cnt_q <= out_cnt_n;
      if (branch_i) begin
        // flush; everything still on the bus gets dropped
        armed_q      <= 1'b1;
        fetch_addr_q <= branch_addr_i;
        resp_addr_q  <= branch_addr_i;
        drop_cnt_q   <= out_cnt_n;
        fifo_cnt_q   <= '0;
        rd_ptr_q     <= '0;
        wr_ptr_q     <= '0;
      end else begin
        if (granted) begin
          fetch_addr_q <= fetch_addr_q + 32'd4;
        end
        if (drop) begin
          drop_cnt_q <= drop_cnt_q - 1'b1;
        end
        // in-order responses, so the address just follows the pushes
        if (push) begin
          resp_addr_q <= resp_addr_q + 32'd4;
          wr_ptr_q    <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        fifo_cnt_q <= fifo_cnt_q + CW'(push) - CW'(pop);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= '{addr: resp_addr_q, rdata: instr_rdata_i};
    end
  end

  // ----------------------------------------
  // bus and queue checks
  // ----------------------------------------
  assert property (@(posedge clk) disable iff (!rst_n) instr_gnt_i |-> instr_req_o)
    else $error("instr bus grant without request");
  assert property (@(posedge clk) disable iff (!rst_n) instr_rvalid_i |-> (out_cnt_q != '0))
    else $error("instr bus rvalid with nothing in flight");
  assert property (@(posedge clk) disable iff (!rst_n) push |-> (fifo_cnt_q < DEPTH))
    else $error("prefetch queue overflow");

endmodule

`default_nettype wire

//--- hdl/fetch_hwloop_ctrl.sv
// lowest matching loop wins; a count of 1 ends the loop without a jump
`timescale 1ns/10ps
`default_nettype none

module fetch_hwloop_ctrl #(
  parameter int N_HWLP = 2
) (
  input  logic [31:0]                     pc_i,
  input  fetch_pkg::hwlp_cfg_t [N_HWLP-1:0] cfg_i,
  output logic                            jump_o,
  output logic [31:0]                     target_o,
  output logic [N_HWLP-1:0]               dec_o
);

  always_comb begin
    jump_o   = 1'b0;
    target_o = '0;
    dec_o    = '0;
    // walk downward so the lowest index is assigned last
    for (int i = N_HWLP - 1; i >= 0; i--) begin
      if (pc_i == cfg_i[i].end_addr && cfg_i[i].count != 32'd0) begin
        dec_o    = '0;
        dec_o[i] = 1'b1;
        // last pass falls through to end + 4
        jump_o   = (cfg_i[i].count > 32'd1);
        target_o = cfg_i[i].start;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetch_hwloop_regs.sv
// one write per cycle; a write to a loop blocks its decrement in that cycle
// the write index is one bit, so only loops 0 and 1 are writable
`timescale 1ns/10ps
`default_nettype none

module fetch_hwloop_regs #(
  parameter int N_HWLP = 2
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  fetch_pkg::hwlp_wr_t             wr_i,
  input  logic [N_HWLP-1:0]               dec_i,
  output fetch_pkg::hwlp_cfg_t [N_HWLP-1:0] cfg_o
);
  import fetch_pkg::*;

  hwlp_cfg_t [N_HWLP-1:0] cfg_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q <= '0;
    end else begin
      for (int i = 0; i < N_HWLP; i++) begin
        if (wr_i.valid && int'(wr_i.idx) == i) begin
          case (wr_i.sel)
            HWLP_SEL_START: cfg_q[i].start    <= wr_i.data;
            HWLP_SEL_END:   cfg_q[i].end_addr <= wr_i.data;
            HWLP_SEL_COUNT: cfg_q[i].count    <= wr_i.data;
            default: ;
          endcase
        end else if (dec_i[i]) begin
          cfg_q[i].count <= cfg_q[i].count - 32'd1;
        end
      end
    end
  end

  assign cfg_o = cfg_q;

  // the IF stage only strobes loops that are still running
  for (genvar g = 0; g < N_HWLP; g++) begin : g_dec_chk
    assert property (@(posedge clk) disable iff (!rst_n) dec_i[g] |-> (cfg_q[g].count != '0))
      else $error("hardware loop %0d decremented at count 0", g);
  end

endmodule

`default_nettype wire

//--- hdl/fetch_compressed_expander.sv
// rv32c subset only; any other 16-bit form, zero included, is flagged illegal
`timescale 1ns/10ps
`default_nettype none

module fetch_compressed_expander (
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);

  logic [15:0] half;
  logic [31:0] c_exp;
  logic        ok;

  // compressed instructions sit in the low half of the word
  assign half            = instr_i[15:0];
  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    c_exp = instr_i;
    ok    = 1'b0;
    // quadrant and funct3
    case ({half[1:0], half[15:13]})
      // c.addi -> addi rd, rd, imm
      5'b01_000: begin
        c_exp = {{6{half[12]}}, half[12], half[6:2], half[11:7], 3'b000,
                 half[11:7], 7'b0010011};
        ok    = 1'b1;
      end
      // c.li -> addi rd, x0, imm
      5'b01_010: begin
        c_exp = {{6{half[12]}}, half[12], half[6:2], 5'd0, 3'b000,
                 half[11:7], 7'b0010011};
        ok    = 1'b1;
      end
      // c.j -> jal x0, offset
      5'b01_101: begin
        c_exp = {half[12], half[8], half[10:9], half[6], half[7], half[2], half[11],
                 half[5:3], half[12], {8{half[12]}}, 5'd0, 7'b1101111};
        ok    = 1'b1;
      end
      // c.lwsp -> lw rd, off(x2)
      5'b10_010: begin
        c_exp = {4'b0, half[3:2], half[12], half[6:4], 2'b00, 5'd2, 3'b010,
                 half[11:7], 7'b0000011};
        // rd of x0 is reserved
        ok    = (half[11:7] != 5'd0);
      end
      // c.swsp -> sw rs2, off(x2)
      5'b10_110: begin
        c_exp = {4'b0, half[8:7], half[12], half[6:2], 5'd2, 3'b010,
                 half[11:9], 2'b00, 7'b0100011};
        ok    = 1'b1;
      end
      // c.jr, c.mv and c.add share funct3 100
      5'b10_100: begin
        if (!half[12] && half[6:2] == 5'd0) begin
          // c.jr -> jalr x0, 0(rs1)
          c_exp = {12'b0, half[11:7], 3'b000, 5'd0, 7'b1100111};
          ok    = (half[11:7] != 5'd0);
        end else if (half[6:2] != 5'd0) begin
          // c.mv reads x0 as rs1, c.add reads rd
          c_exp = {7'b0, half[6:2], (half[12] ? half[11:7] : 5'd0), 3'b000,
                   half[11:7], 7'b0110011};
          ok    = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // illegal halves go out raw
  assign instr_o   = (is_compressed_o && ok) ? c_exp : instr_i;
  assign illegal_o = is_compressed_o & ~ok;

endmodule

`default_nettype wire

//--- hdl/fetch_if_stage.sv
// one instruction per 32-bit word and pc steps by 4; machine-mode traps only
// the first req_i after reset always fetches from boot_addr_i
`timescale 1ns/10ps
`default_nettype none

module fetch_if_stage #(
  parameter int          N_HWLP         = 2,
  parameter int          PREFETCH_DEPTH = 4,
  parameter logic [31:0] DM_HALT_ADDR   = fetch_pkg::DEFAULT_DM_HALT_ADDR
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            req_i,
  input  logic [31:0]                     boot_addr_i,
  input  logic [23:0]                     mtvec_base_i,
  input  logic                            pc_set_i,
  input  fetch_pkg::pc_sel_e              pc_mux_i,
  input  fetch_pkg::exc_sel_e             exc_pc_mux_i,
  input  logic [4:0]                      exc_vec_i,
  input  logic [31:0]                     jump_target_id_i,
  input  logic [31:0]                     jump_target_ex_i,
  input  logic [31:0]                     mepc_i,
  input  logic [31:0]                     depc_i,
  output logic                            instr_req_o,
  output logic [31:0]                     instr_addr_o,
  input  logic                            instr_gnt_i,
  input  logic                            instr_rvalid_i,
  input  logic [31:0]                     instr_rdata_i,
  input  fetch_pkg::hwlp_cfg_t [N_HWLP-1:0] hwlp_cfg_i,
  output logic [N_HWLP-1:0]               hwlp_dec_o,
  input  logic                            halt_if_i,
  input  logic                            id_ready_i,
  input  logic                            clear_instr_valid_i,
  output logic                            instr_valid_id_o,
  output fetch_pkg::if_id_t               if_id_o,
  output logic [31:0]                     pc_if_o,
  output logic                            if_busy_o,
  output logic                            perf_imiss_o
);
  import fetch_pkg::*;

  typedef enum logic {IDLE, WAIT} fsm_e;

  fsm_e              fsm_q;
  fetch_word_t       fetch_word;
  logic              fetch_valid, prefetch_busy, if_valid;
  logic              branch_req, hwlp_jump;
  logic [31:0]       branch_addr, fetch_addr_n, exc_pc, hwlp_target;
  logic [N_HWLP-1:0] hwlp_dec;
  logic [31:0]       instr_exp;
  logic              instr_is_c, instr_illegal_c;

  // ----------------------------------------
  // redirect address
  // ----------------------------------------
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_IRQ: exc_pc = {mtvec_base_i, 1'b0, exc_vec_i, 2'b00};
      EXC_PC_DBD: exc_pc = DM_HALT_ADDR;
      default:    exc_pc = {mtvec_base_i, 8'h00};
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      PC_JUMP:      fetch_addr_n = jump_target_id_i;
      PC_BRANCH:    fetch_addr_n = jump_target_ex_i;
      PC_EXCEPTION: fetch_addr_n = exc_pc;
      PC_MRET:      fetch_addr_n = mepc_i;
      PC_DRET:      fetch_addr_n = depc_i;
      // refetch right after the fence.i in ID
      PC_FENCEI:    fetch_addr_n = if_id_o.pc + 32'd4;
      default:      fetch_addr_n = boot_addr_i;
    endcase
  end

  // pc_set_i beats the boot start, which beats a loop jump
  always_comb begin
    if (pc_set_i) begin
      branch_addr = fetch_addr_n;
    end else if (fsm_q == IDLE) begin
      branch_addr = boot_addr_i;
    end else begin
      branch_addr = hwlp_target;
    end
  end

  // ----------------------------------------
  // request FSM
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fsm_q <= IDLE;
    end else if (req_i || pc_set_i) begin
      fsm_q <= WAIT;
    end
  end

  // a word moves into IF/ID only with no stall and no redirect
  assign if_valid   = (fsm_q == WAIT) & fetch_valid & id_ready_i & ~halt_if_i & ~pc_set_i;
  assign branch_req = pc_set_i | ((fsm_q == IDLE) & req_i) | (if_valid & hwlp_jump);

  fetch_prefetch_buffer #(
    .DEPTH (PREFETCH_DEPTH)
  ) prefetch_buffer_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_req),
    .branch_addr_i  ({branch_addr[31:2], 2'b00}),
    .ready_i        (if_valid),
    .valid_o        (fetch_valid),
    .word_o         (fetch_word),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .busy_o         (prefetch_busy)
  );

  // loop end check on the word at the head of the queue
  fetch_hwloop_ctrl #(
    .N_HWLP (N_HWLP)
  ) hwloop_ctrl_i (
    .pc_i     (fetch_word.addr),
    .cfg_i    (hwlp_cfg_i),
    .jump_o   (hwlp_jump),
    .target_o (hwlp_target),
    .dec_o    (hwlp_dec)
  );

  fetch_compressed_expander expander_i (
    .instr_i         (fetch_word.rdata),
    .instr_o         (instr_exp),
    .is_compressed_o (instr_is_c),
    .illegal_o       (instr_illegal_c)
  );

  // one strobe per accepted loop-end word
  assign hwlp_dec_o   = hwlp_dec & {N_HWLP{if_valid}};
  assign pc_if_o      = fetch_word.addr;
  assign if_busy_o    = prefetch_busy;
  assign perf_imiss_o = ((fsm_q == WAIT) & ~fetch_valid) | branch_req;

  // ----------------------------------------
  // IF/ID register
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o <= 1'b0;
    end else if (if_valid) begin
      instr_valid_id_o <= 1'b1;
    end else if (clear_instr_valid_i) begin
      instr_valid_id_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid) begin
      if_id_o.instr         <= instr_exp;
      if_id_o.pc            <= fetch_word.addr;
      if_id_o.is_compressed <= instr_is_c;
      if_id_o.illegal_c     <= instr_illegal_c;
      if_id_o.is_hwlp       <= hwlp_jump;
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetch_frontend_top.sv
// fetch front end with its loop registers; loops are written over hwlp_wr_i
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend_top #(
  parameter int          N_HWLP         = 2,
  parameter int          PREFETCH_DEPTH = 4,
  parameter logic [31:0] DM_HALT_ADDR   = fetch_pkg::DEFAULT_DM_HALT_ADDR
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_i,
  input  logic [31:0]         boot_addr_i,
  input  logic [23:0]         mtvec_base_i,
  input  logic                pc_set_i,
  input  fetch_pkg::pc_sel_e  pc_mux_i,
  input  fetch_pkg::exc_sel_e exc_pc_mux_i,
  input  logic [4:0]          exc_vec_i,
  input  logic [31:0]         jump_target_id_i,
  input  logic [31:0]         jump_target_ex_i,
  input  logic [31:0]         mepc_i,
  input  logic [31:0]         depc_i,
  output logic                instr_req_o,
  output logic [31:0]         instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic [31:0]         instr_rdata_i,
  input  fetch_pkg::hwlp_wr_t hwlp_wr_i,
  input  logic                halt_if_i,
  input  logic                id_ready_i,
  input  logic                clear_instr_valid_i,
  output logic                instr_valid_id_o,
  output fetch_pkg::if_id_t   if_id_o,
  output logic [31:0]         pc_if_o,
  output logic                if_busy_o,
  output logic                perf_imiss_o
);
  import fetch_pkg::*;

  hwlp_cfg_t [N_HWLP-1:0] hwlp_cfg;
  logic [N_HWLP-1:0]      hwlp_dec;

  fetch_if_stage #(
    .N_HWLP         (N_HWLP),
    .PREFETCH_DEPTH (PREFETCH_DEPTH),
    .DM_HALT_ADDR   (DM_HALT_ADDR)
  ) if_stage_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .req_i               (req_i),
    .boot_addr_i         (boot_addr_i),
    .mtvec_base_i        (mtvec_base_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .exc_vec_i           (exc_vec_i),
    .jump_target_id_i    (jump_target_id_i),
    .jump_target_ex_i    (jump_target_ex_i),
    .mepc_i              (mepc_i),
    .depc_i              (depc_i),
    .instr_req_o         (instr_req_o),
    .instr_addr_o        (instr_addr_o),
    .instr_gnt_i         (instr_gnt_i),
    .instr_rvalid_i      (instr_rvalid_i),
    .instr_rdata_i       (instr_rdata_i),
    .hwlp_cfg_i          (hwlp_cfg),
    .hwlp_dec_o          (hwlp_dec),
    .halt_if_i           (halt_if_i),
    .id_ready_i          (id_ready_i),
    .clear_instr_valid_i (clear_instr_valid_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .if_id_o             (if_id_o),
    .pc_if_o             (pc_if_o),
    .if_busy_o           (if_busy_o),
    .perf_imiss_o        (perf_imiss_o)
  );

  // count, start and end of every loop
  fetch_hwloop_regs #(
    .N_HWLP (N_HWLP)
  ) hwloop_regs_i (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_i  (hwlp_wr_i),
    .dec_i (hwlp_dec),
    .cfg_o (hwlp_cfg)
  );

endmodule

`default_nettype wire

//--- testbench/fetch_frontend_tb.sv
// directed tests of the fetch front end against a memory model with random bus delays
// the ID side keeps clear_instr_valid_i high, so every IF/ID load shows as a 1-cycle valid
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend_tb;
  import fetch_pkg::*;

  localparam int          PREFETCH_DEPTH = 4;
  localparam logic [31:0] BOOT_ADDR      = 32'h0000_1000;
  localparam logic [31:0] JUMP_ID_ADDR   = 32'h0000_2000;
  localparam logic [31:0] JUMP_EX_ADDR   = 32'h0000_3000;
  localparam logic [23:0] MTVEC_BASE     = 24'h00_0040;
  localparam logic [4:0]  IRQ_VEC        = 5'd11;
  localparam logic [31:0] MEPC_ADDR      = 32'h0000_5004;
  localparam logic [31:0] DEPC_ADDR      = 32'h0000_6008;
  localparam logic [31:0] HALT_ADDR      = 32'h0000_9800;
  localparam logic [31:0] C_BASE         = 32'h0000_7000;
  localparam logic [15:0] C_UPPER        = 16'hA5A5;
  localparam logic [31:0] LOOP_START     = 32'h0000_8000;
  localparam logic [31:0] LOOP_END       = 32'h0000_800C;
  localparam int          LOOP_LEN       = 4;
  localparam int          LOOP_COUNT     = 3;
  // instructions over all tests: 16 + 24 + 9*4 + 10 + 14
  localparam int          N_INSTR        = 100;
  // worst redirect latency incl. stale responses, in cycles
  localparam int          WORST_LAT      = 20;
  localparam int          TIMEOUT_CYCLES = N_INSTR * WORST_LAT * 2;

  logic        clk, rst_n, req_i;
  logic [31:0] boot_addr_i, jump_target_id_i, jump_target_ex_i, mepc_i, depc_i;
  logic [23:0] mtvec_base_i;
  logic        pc_set_i;
  pc_sel_e     pc_mux_i;
  exc_sel_e    exc_pc_mux_i;
  logic [4:0]  exc_vec_i;
  logic        instr_req_o, instr_gnt_i, instr_rvalid_i, gnt_en;
  logic [31:0] instr_addr_o, instr_rdata_i, pc_if_o;
  hwlp_wr_t    hwlp_wr_i;
  logic        halt_if_i, id_ready_i, clear_instr_valid_i;
  logic        instr_valid_id_o, if_busy_o, perf_imiss_o;
  if_id_t      if_id_o;

  integer      seed = 32'hac2c_809a;
  int unsigned cycle_cnt;
  logic [31:0] mem_over [logic [31:0]];
  logic [31:0] rsp_addr_q [$];
  int unsigned rsp_due_q [$];
  if_id_t      acc_q [$];
  // instructions of the old stream seen up to a redirect
  int          old_len;

  // grant can only follow a live request
  assign instr_gnt_i = instr_req_o & gnt_en;

  fetch_frontend_top #(
    .N_HWLP         (2),
    .PREFETCH_DEPTH (PREFETCH_DEPTH),
    .DM_HALT_ADDR   (HALT_ADDR)
  ) fetch_frontend_top_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .req_i               (req_i),
    .boot_addr_i         (boot_addr_i),
    .mtvec_base_i        (mtvec_base_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .exc_vec_i           (exc_vec_i),
    .jump_target_id_i    (jump_target_id_i),
    .jump_target_ex_i    (jump_target_ex_i),
    .mepc_i              (mepc_i),
    .depc_i              (depc_i),
    .instr_req_o         (instr_req_o),
    .instr_addr_o        (instr_addr_o),
    .instr_gnt_i         (instr_gnt_i),
    .instr_rvalid_i      (instr_rvalid_i),
    .instr_rdata_i       (instr_rdata_i),
    .hwlp_wr_i           (hwlp_wr_i),
    .halt_if_i           (halt_if_i),
    .id_ready_i          (id_ready_i),
    .clear_instr_valid_i (clear_instr_valid_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .if_id_o             (if_id_o),
    .pc_if_o             (pc_if_o),
    .if_busy_o           (if_busy_o),
    .perf_imiss_o        (perf_imiss_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------
  // memory, checks and helpers
  // ----------------------------------------
  // untouched words are full 32-bit instructions
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    if (mem_over.exists(addr)) begin
      return mem_over[addr];
    end
    return {addr[31:2] ^ {addr[17:2], addr[31:18]}, 2'b11};
  endfunction

  function automatic if_id_t expect_plain(input logic [31:0] pc);
    return '{instr: mem_word(pc), pc: pc, is_compressed: 1'b0, illegal_c: 1'b0,
             is_hwlp: 1'b0};
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_if_id(input string name, input if_id_t got, input if_id_t exp);
    if (got !== exp) begin
      report_error($sformatf("Fail %s at pc %h: got %h expected %h", name, exp.pc, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bool(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  // one grant per request after 0..2 cycles, rvalid 1..3 cycles later, in order
  initial begin : memory_model
    int unsigned wait_cnt;
    int unsigned due;
    int unsigned last_due;
    wait_cnt = 0;
    last_due = 0;
    forever begin
      @(negedge clk);
      if (instr_req_o && instr_gnt_i) begin
        due = cycle_cnt + 1 + ($unsigned($random(seed)) % 3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_addr_q.push_back(instr_addr_o);
        rsp_due_q.push_back(due);
        wait_cnt = $unsigned($random(seed)) % 3;
      end else if (instr_req_o && wait_cnt != 0) begin
        wait_cnt = wait_cnt - 1;
      end
      check_bool("granted and unanswered within depth", rsp_addr_q.size() <= PREFETCH_DEPTH,
                 1'b1);
      @(posedge clk);
      #1;
      gnt_en = (wait_cnt == 0);
      if (rsp_due_q.size() != 0 && rsp_due_q[0] == cycle_cnt) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = mem_word(rsp_addr_q[0]);
        void'(rsp_addr_q.pop_front());
        void'(rsp_due_q.pop_front());
      end else begin
        instr_rvalid_i = 1'b0;
      end
    end
  end

  // ID side, records every IF/ID load
  initial begin : id_consumer
    forever begin
      @(negedge clk);
      if (rst_n && instr_valid_id_o) begin
        acc_q.push_back(if_id_o);
      end
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
        report_error("timeout: the fetch front end stopped delivering instructions");
      end
    end
  end

  task automatic wait_accepts(input int n);
    while (acc_q.size() < n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic expect_sequential(input logic [31:0] start_pc, input int n);
    wait_accepts(n);
    for (int i = 0; i < n; i++) begin
      check_if_id("if_id_o", acc_q[i], expect_plain(start_pc + 32'(4 * i)));
    end
  endtask

  // one-cycle pc_set; the queue is cleared once the old stream is blocked
  task automatic redirect(input pc_sel_e sel, input exc_sel_e exc);
    @(posedge clk);
    #1;
    pc_mux_i     = sel;
    exc_pc_mux_i = exc;
    pc_set_i     = 1'b1;
    @(posedge clk);
    #1;
    pc_set_i = 1'b0;
    old_len  = acc_q.size();
    acc_q.delete();
  endtask

  task automatic write_hwlp(input logic idx, input logic [1:0] sel, input logic [31:0] data);
    @(posedge clk);
    #1;
    hwlp_wr_i = '{valid: 1'b1, idx: idx, sel: sel, data: data};
    @(posedge clk);
    #1;
    hwlp_wr_i.valid = 1'b0;
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_boot_stream();
    check_bool("instr_req_o after reset", instr_req_o, 1'b0);
    check_bool("instr_valid_id_o after reset", instr_valid_id_o, 1'b0);
    check_bool("if_busy_o after reset", if_busy_o, 1'b0);
    check_bool("perf_imiss_o after reset", perf_imiss_o, 1'b0);
    acc_q.delete();
    req_i = 1'b1;
    expect_sequential(BOOT_ADDR, 16);
  endtask

  task automatic test_backpressure();
    logic [31:0] start_pc;
    logic [31:0] rnd;
    int          k;
    // the boot stream runs on without a gap
    start_pc = BOOT_ADDR + 32'(4 * acc_q.size());
    acc_q.delete();
    k = 0;
    while (acc_q.size() < 24) begin
      rnd        = $random(seed);
      id_ready_i = rnd[0];
      halt_if_i  = (k % 7 == 3);
      k++;
      @(posedge clk);
      #1;
    end
    // full stall until the queue is full and the bus idle
    id_ready_i = 1'b0;
    halt_if_i  = 1'b0;
    @(posedge clk);
    #1;
    while (if_busy_o) begin
      @(posedge clk);
      #1;
    end
    check_addr("pc_if_o", pc_if_o, start_pc + 32'(4 * acc_q.size()));
    check_bool("perf_imiss_o with full queue", perf_imiss_o, 1'b0);
    check_bool("instr_valid_id_o while stalled", instr_valid_id_o, 1'b0);
    id_ready_i = 1'b1;
    expect_sequential(start_pc, 24);
  endtask

  task automatic check_redirect(input pc_sel_e sel, input exc_sel_e exc,
                                input logic [31:0] target, input string name);
    logic [31:0] exp_pc;
    redirect(sel, exc);
    // fence.i restarts behind the last instruction of the stream starting at target
    exp_pc = (sel == PC_FENCEI) ? target + 32'(4 * old_len) : target;
    wait_accepts(1);
    check_addr(name, acc_q[0].pc, exp_pc);
    expect_sequential(exp_pc, 4);
  endtask

  task automatic test_redirects();
    check_redirect(PC_JUMP, EXC_PC_EXCEPTION, JUMP_ID_ADDR, "jump pc");
    check_redirect(PC_BRANCH, EXC_PC_EXCEPTION, JUMP_EX_ADDR, "branch pc");
    check_redirect(PC_EXCEPTION, EXC_PC_EXCEPTION, {MTVEC_BASE, 8'h00}, "exception pc");
    check_redirect(PC_EXCEPTION, EXC_PC_IRQ, {MTVEC_BASE, 8'h00} + 32'd4 * IRQ_VEC, "irq pc");
    check_redirect(PC_EXCEPTION, EXC_PC_DBD, HALT_ADDR, "debug halt pc");
    check_redirect(PC_MRET, EXC_PC_EXCEPTION, MEPC_ADDR, "mret pc");
    check_redirect(PC_DRET, EXC_PC_EXCEPTION, DEPC_ADDR, "dret pc");
    check_redirect(PC_FENCEI, EXC_PC_EXCEPTION, DEPC_ADDR, "fence.i pc");
    check_redirect(PC_BOOT, EXC_PC_EXCEPTION, BOOT_ADDR, "boot pc");
  endtask

  task automatic test_compressed();
    logic [15:0] half [10];
    logic [31:0] exp_instr [10];
    logic        exp_ill [10];
    if_id_t      exp;
    // c.addi, c.li, c.lwsp, c.swsp, c.j, c.jr, c.mv, c.add, zero, c.flw
    half      = '{16'h0415, 16'h557D, 16'h44A2, 16'hC62E, 16'hA801,
                  16'h8082, 16'h8636, 16'h973E, 16'h0000, 16'h6000};
    exp_instr = '{32'h0054_0413, 32'hFFF0_0513, 32'h0081_2483, 32'h00B1_2623, 32'h0100_006F,
                  32'h0000_8067, 32'h00D0_0633, 32'h00F7_0733, 32'hA5A5_0000, 32'hA5A5_6000};
    exp_ill   = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
    for (int i = 0; i < 10; i++) begin
      mem_over[C_BASE + 32'(4 * i)] = {C_UPPER, half[i]};
    end
    jump_target_id_i = C_BASE;
    redirect(PC_JUMP, EXC_PC_EXCEPTION);
    wait_accepts(10);
    for (int i = 0; i < 10; i++) begin
      exp = '{instr: exp_instr[i], pc: C_BASE + 32'(4 * i), is_compressed: 1'b1,
              illegal_c: exp_ill[i], is_hwlp: 1'b0};
      check_if_id("if_id_o compressed", acc_q[i], exp);
    end
  endtask

  task automatic test_hwloop();
    if_id_t exp;
    int     idx;
    // count goes last so the loop is never live with a stale end
    write_hwlp(1'b0, HWLP_SEL_START, LOOP_START);
    write_hwlp(1'b0, HWLP_SEL_END, LOOP_END);
    write_hwlp(1'b0, HWLP_SEL_COUNT, 32'(LOOP_COUNT));
    jump_target_id_i = LOOP_START;
    redirect(PC_JUMP, EXC_PC_EXCEPTION);
    wait_accepts(LOOP_COUNT * LOOP_LEN + 2);
    idx = 0;
    for (int p = 0; p < LOOP_COUNT; p++) begin
      for (int w = 0; w < LOOP_LEN; w++) begin
        exp = expect_plain(LOOP_START + 32'(4 * w));
        // last pass falls through without a jump
        exp.is_hwlp = (w == LOOP_LEN - 1) && (p != LOOP_COUNT - 1);
        check_if_id("if_id_o loop", acc_q[idx], exp);
        idx++;
      end
    end
    for (int t = 0; t < 2; t++) begin
      check_if_id("if_id_o after loop", acc_q[idx + t], expect_plain(LOOP_END + 32'(4 * t + 4)));
    end
  endtask

  initial begin
    rst_n               = 1'b0;
    req_i               = 1'b0;
    boot_addr_i         = BOOT_ADDR;
    mtvec_base_i        = MTVEC_BASE;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXCEPTION;
    exc_vec_i           = IRQ_VEC;
    jump_target_id_i    = JUMP_ID_ADDR;
    jump_target_ex_i    = JUMP_EX_ADDR;
    mepc_i              = MEPC_ADDR;
    depc_i              = DEPC_ADDR;
    gnt_en              = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = '0;
    hwlp_wr_i           = '0;
    halt_if_i           = 1'b0;
    id_ready_i          = 1'b1;
    clear_instr_valid_i = 1'b1;
    old_len             = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    test_boot_stream();
    test_backpressure();
    test_redirects();
    test_compressed();
    test_hwloop();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_frontend_top.f
hdl/fetch_pkg.sv
hdl/fetch_prefetch_buffer.sv
hdl/fetch_hwloop_ctrl.sv
hdl/fetch_hwloop_regs.sv
hdl/fetch_compressed_expander.sv
hdl/fetch_if_stage.sv
hdl/fetch_frontend_top.sv
testbench/fetch_frontend_tb.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - hdl/fetch_pkg.sv
  - hdl/fetch_prefetch_buffer.sv
  - hdl/fetch_hwloop_ctrl.sv
  - hdl/fetch_hwloop_regs.sv
  - hdl/fetch_compressed_expander.sv
  - hdl/fetch_if_stage.sv
  - hdl/fetch_frontend_top.sv
  - target: simulation
    files:
      - testbench/fetch_frontend_tb.sv
